// ==== all.f ====
fpu_ops_pkg.sv
fpu_fmt_pkg.sv
fpu_addsub.sv
fpu_mul.sv
fpu_rnd.sv
fpu_top.sv
fpu_rnd_props.sv
tb_fpu.sv

// ==== fpu_addsub.sv ====
// one register stage; exact zero sums of opposite signs give +0, or -0 when rounding to -inf
`timescale 1ns/10ps
module fpu_addsub import fpu_ops_pkg::*, fpu_fmt_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        start_i,
  input  fpu_op_e     op_i,
  input  logic [31:0] opa_i,
  input  logic [31:0] opb_i,
  input  fpu_rmode_e  rmode_i,
  input  logic        adv_i,
  input  logic        flush_i,
  output fp_unrnd_t   res_o
);

  fp_opnd_t    a, b_raw, b;
  fp_opnd_t    lg, sm;       // larger / smaller magnitude
  logic        sub_op;
  logic        eff_sub;
  logic        a_ge_b;
  logic [7:0]  exp_diff;
  logic [4:0]  shamt;
  logic [50:0] sm_wide;
  logic [26:0] lg_ext, sm_ext;  // mant + guard, round, sticky
  logic [27:0] sum;
  logic [4:0]  lz;
  logic [27:0] norm;
  logic        sum_zero;
  fp_unrnd_t   res_d, res_q;
  logic        rdy_q;

  // leading zeros of the raw sum, 28 when all zero
  function automatic logic [4:0] clz28(input logic [27:0] v);
    logic [4:0] n;
    logic       hit;
    n   = 5'd0;
    hit = 1'b0;
    for (int i = 27; i >= 0; i--) begin
      if (!hit && !v[i]) n = n + 5'd1;
      else hit = 1'b1;
    end
    return n;
  endfunction

  ////////////////////////////////////////
  // unpack, swap, align
  ////////////////////////////////////////

  assign a      = fp_unpack(opa_i);
  assign b_raw  = fp_unpack(opb_i);
  assign sub_op = (op_i == FPU_SUB);

  always_comb begin
    b      = b_raw;
    b.sign = b_raw.sign ^ sub_op;  // a - b == a + (-b)
  end

  assign a_ge_b   = {a.exp, a.mant} >= {b.exp, b.mant};
  assign lg       = a_ge_b ? a : b;
  assign sm       = a_ge_b ? b : a;
  assign eff_sub  = lg.sign ^ sm.sign;
  assign exp_diff = lg.exp - sm.exp;
  assign shamt    = (exp_diff > 8'd27) ? 5'd27 : exp_diff[4:0];  // beyond 27 only sticky

  // wide shift keeps every lost bit for the sticky OR
  assign sm_wide = {sm.mant, 27'd0} >> shamt;
  assign sm_ext  = {sm_wide[50:25], |sm_wide[24:0]};
  assign lg_ext  = {lg.mant, 3'd0};

  ////////////////////////////////////////
  // add / subtract and normalize
  ////////////////////////////////////////

  // lg >= sm, so no borrow out on subtract
  assign sum = eff_sub ? ({1'b0, lg_ext} - {1'b0, sm_ext})
                       : ({1'b0, lg_ext} + {1'b0, sm_ext});

  assign lz       = clz28(sum);
  assign norm     = sum << lz;  // hidden bit lands at 27
  assign sum_zero = (sum == 28'd0);

  always_comb begin
    res_d          = '0;
    res_d.rdy      = start_i & ((op_i == FPU_ADD) | sub_op);
    res_d.sign     = (sum_zero & eff_sub) ? (rmode_i == RM_TO_INFM) : lg.sign;
    res_d.exp10    = $signed({2'b00, lg.exp}) + 10'sd1 - $signed({5'd0, lz});  // bit 27 = +1
    res_d.fract24  = norm[27:4];
    res_d.rs       = {norm[3], |norm[2:0]};
    res_d.inv      = a.inf & b.inf & eff_sub;  // inf - inf
    res_d.inf      = a.inf | b.inf;
    res_d.snan     = a.snan | b.snan;
    res_d.qnan     = a.qnan | b.qnan;
    res_d.nan_sign = (a.snan | a.qnan) ? a.sign : b_raw.sign;
  end

  ////////////////////////////////////////
  // stage register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) res_q <= res_d;
  end

  always_ff @(posedge clk) begin
    if (rst)          rdy_q <= 1'b0;
    else if (flush_i) rdy_q <= 1'b0;  // flush beats advance
    else if (adv_i)   rdy_q <= res_d.rdy;
  end

  always_comb begin
    res_o     = res_q;
    res_o.rdy = rdy_q;
  end

endmodule

// ==== fpu_fmt_pkg.sv ====
// binary32 only; denormal inputs unpack as signed zero and nan payloads are dropped
package fpu_fmt_pkg;

  localparam logic signed [9:0] FP_BIAS    = 10'sd127;
  localparam logic signed [9:0] FP_EXP_MAX = 10'sd254;  // largest finite biased exp
  localparam logic [7:0]        FP_EXP_INF = 8'hFF;     // inf and nan exponent

  localparam logic [30:0] QNAN_BITS = 31'h7FC00000;  // canonical quiet nan, no sign
  localparam logic [30:0] INF_BITS  = 31'h7F800000;

  // raw binary32 word
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } fp32_t;

  // operand after unpacking
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [23:0] mant;  // hidden bit at 23, all zero for zero/denormal
    logic        zero;
    logic        inf;
    logic        snan;
    logic        qnan;
  } fp_opnd_t;

  // unrounded result of one unit, 44 bits
  typedef struct packed {
    logic              rdy;
    logic              sign;
    logic signed [9:0] exp10;     // biased, may under/overflow
    logic [23:0]       fract24;   // hidden bit at 23
    logic [1:0]        rs;        // round, sticky
    logic              inv;       // invalid operation
    logic              inf;       // infinity result
    logic              snan;      // signalling nan seen
    logic              qnan;      // quiet nan seen
    logic              nan_sign;
    logic              pad;
  } fp_unrnd_t;

  // exception flags
  typedef struct packed {
    logic ovf;
    logic unf;
    logic snf;
    logic qnf;
    logic zf;
    logic ixf;
    logic ivf;
  } fp_flags_t;

  // field split and class decode, shared by both units
  function automatic fp_opnd_t fp_unpack(input logic [31:0] w);
    fp32_t    f;
    fp_opnd_t o;
    f      = w;
    o.sign = f.sign;
    o.exp  = f.exp;
    o.zero = (f.exp == 8'd0);                     // denormals flushed here
    o.mant = o.zero ? 24'd0 : {1'b1, f.frac};
    o.inf  = (f.exp == FP_EXP_INF) && (f.frac == 23'd0);
    o.qnan = (f.exp == FP_EXP_INF) && f.frac[22];
    o.snan = (f.exp == FP_EXP_INF) && !f.frac[22] && (f.frac != 23'd0);
    return o;
  endfunction

endpackage

// ==== fpu_mul.sv ====
// one register stage; zero or denormal operands give a zero product of xor sign
`timescale 1ns/10ps
module fpu_mul import fpu_ops_pkg::*, fpu_fmt_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        start_i,
  input  fpu_op_e     op_i,
  input  logic [31:0] opa_i,
  input  logic [31:0] opb_i,
  input  logic        adv_i,
  input  logic        flush_i,
  output fp_unrnd_t   res_o
);

  fp_opnd_t    a, b;
  logic [47:0] prod;
  logic        hi;      // product in [2,4)
  fp_unrnd_t   res_d, res_q;
  logic        rdy_q;

  assign a    = fp_unpack(opa_i);
  assign b    = fp_unpack(opb_i);
  assign prod = a.mant * b.mant;  // 24x24 -> 48
  assign hi   = prod[47];

  ////////////////////////////////////////
  // product and specials
  ////////////////////////////////////////

  always_comb begin
    res_d         = '0;
    res_d.rdy     = start_i & (op_i == FPU_MUL);
    res_d.sign    = a.sign ^ b.sign;
    // ea + eb - bias, +1 when normalizing right by one
    res_d.exp10   = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp}) - FP_BIAS
                    + $signed({9'd0, hi});
    res_d.fract24 = hi ? prod[47:24] : prod[46:23];
    res_d.rs      = hi ? {prod[23], |prod[22:0]}
                       : {prod[22], |prod[21:0]};
    res_d.inv     = (a.zero & b.inf) | (a.inf & b.zero);  // 0 * inf
    res_d.inf     = a.inf | b.inf;
    res_d.snan    = a.snan | b.snan;
    res_d.qnan    = a.qnan | b.qnan;
    res_d.nan_sign = (a.snan | a.qnan) ? a.sign : b.sign;
  end

  ////////////////////////////////////////
  // stage register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) res_q <= res_d;  // payload
  end

  always_ff @(posedge clk) begin
    if (rst)          rdy_q <= 1'b0;
    else if (flush_i) rdy_q <= 1'b0;
    else if (adv_i)   rdy_q <= res_d.rdy;
  end

  always_comb begin
    res_o     = res_q;
    res_o.rdy = rdy_q;
  end

endmodule

// ==== fpu_ops_pkg.sv ====
// opcode and rounding mode encodings only; FPU_SUB is decoded by the add unit alone
package fpu_ops_pkg;

  ////////////////////////////////////////
  // operations
  ////////////////////////////////////////

  // opcode, seen by both units at once
  typedef enum logic [1:0] {
    FPU_ADD = 2'd0,
    FPU_SUB = 2'd1,  // add unit flips sign of b
    FPU_MUL = 2'd2
  } fpu_op_e;

  ////////////////////////////////////////
  // rounding
  ////////////////////////////////////////

  // 2-bit rounding mode, same order as the usual fpcsr field
  typedef enum logic [1:0] {
    RM_NEAREST = 2'd0,  // ties to even
    RM_TO_ZERO = 2'd1,  // truncate
    RM_TO_INFP = 2'd2,  // toward +inf
    RM_TO_INFM = 2'd3   // toward -inf
  } fpu_rmode_e;

endpackage

// ==== fpu_rnd.sv ====
// two stages; rmode_i is used unregistered and must stay stable while ops are in flight
`timescale 1ns/10ps
module fpu_rnd import fpu_ops_pkg::*, fpu_fmt_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        adv_i,
  input  logic        flush_i,
  input  fpu_rmode_e  rmode_i,
  input  fp_unrnd_t   add_i,
  input  fp_unrnd_t   mul_i,
  output logic [31:0] result_o,
  output logic        valid_o,
  output fp_flags_t   flags_o
);

  // stage 1 record, fraction widened for the rounding carry
  typedef struct packed {
    logic              sign;
    logic signed [9:0] exp10;
    logic [24:0]       fract25;
    logic              lost;
    logic              inv;
    logic              inf;
    logic              snan;
    logic              qnan;
    logic              nan_sign;
  } rnd_s1_t;

  fp_unrnd_t         s1t;
  logic              s1t_g, s1t_r, s1t_s;
  logic              s1t_lost;
  logic              s1t_rnd_up;
  rnd_s1_t           s1d, s1o;
  logic              s1o_rdy;
  logic              s2t_shr;
  logic signed [9:0] s2t_exp10;
  logic [23:0]       s2t_fract24;
  logic              s2t_nz;
  logic [31:0]       s2t_res;
  fp_flags_t         s2t_flags;

  ////////////////////////////////////////
  // stage 1: select and round
  ////////////////////////////////////////

  // add wins, both units never ready together anyway
  assign s1t = add_i.rdy ? add_i :
               mul_i.rdy ? mul_i : '0;

  assign s1t_g    = s1t.fract24[0];  // lsb kept, for ties to even
  assign s1t_r    = s1t.rs[1];
  assign s1t_s    = s1t.rs[0];
  assign s1t_lost = s1t_r | s1t_s;

  always_comb begin
    case (rmode_i)
      RM_NEAREST: s1t_rnd_up = s1t_r & (s1t_s | s1t_g);
      RM_TO_ZERO: s1t_rnd_up = 1'b0;
      RM_TO_INFP: s1t_rnd_up = !s1t.sign & s1t_lost;
      RM_TO_INFM: s1t_rnd_up = s1t.sign & s1t_lost;
    endcase
  end

  always_comb begin
    s1d.sign     = s1t.sign;
    s1d.exp10    = s1t.exp10;
    s1d.fract25  = {1'b0, s1t.fract24} + {24'd0, s1t_rnd_up};
    s1d.lost     = s1t_lost;
    s1d.inv      = s1t.inv;
    s1d.inf      = s1t.inf;
    s1d.snan     = s1t.snan;
    s1d.qnan     = s1t.qnan;
    s1d.nan_sign = s1t.nan_sign;
  end

  always_ff @(posedge clk) begin
    if (adv_i) s1o <= s1d;
  end

  always_ff @(posedge clk) begin
    if (rst)          s1o_rdy <= 1'b0;
    else if (flush_i) s1o_rdy <= 1'b0;
    else if (adv_i)   s1o_rdy <= add_i.rdy | mul_i.rdy;
  end

  ////////////////////////////////////////
  // stage 2: carry, pack, flags
  ////////////////////////////////////////

  assign s2t_shr     = s1o.fract25[24];  // rounding carried out
  assign s2t_exp10   = s1o.exp10 + $signed({9'd0, s2t_shr});
  assign s2t_fract24 = s2t_shr ? s1o.fract25[24:1] : s1o.fract25[23:0];
  assign s2t_nz      = |s2t_fract24;

  always_comb begin
    s2t_res   = '0;
    s2t_flags = '0;
    if (s1o.snan | s1o.qnan) begin
      // nan in, canonical quiet nan out
      s2t_res       = {s1o.nan_sign, QNAN_BITS};
      s2t_flags.qnf = s1o.qnan;
      s2t_flags.snf = s1o.snan;
      s2t_flags.ivf = s1o.snan;
    end else if (s1o.inv) begin
      s2t_res       = {1'b0, QNAN_BITS};  // inf - inf, 0 * inf
      s2t_flags.ivf = 1'b1;
    end else if ((s2t_exp10 > FP_EXP_MAX) | s1o.inf) begin
      s2t_res       = {s1o.sign, INF_BITS};
      s2t_flags.ovf = !s1o.inf;  // only a real overflow
      s2t_flags.ixf = !s1o.inf;
    end else if ((s2t_exp10 <= 10'sd0) | !s2t_nz) begin
      // no denormal output, flush to signed zero
      s2t_res       = {s1o.sign, 31'd0};
      s2t_flags.zf  = 1'b1;
      s2t_flags.unf = s2t_nz;
      s2t_flags.ixf = s2t_nz;
    end else begin
      s2t_res       = {s1o.sign, s2t_exp10[7:0], s2t_fract24[22:0]};
      s2t_flags.ixf = s1o.lost;
    end
  end

  // output register, cleared by reset and flush
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      valid_o  <= 1'b0;
      result_o <= 32'd0;
      flags_o  <= '0;
    end else if (adv_i) begin
      valid_o  <= s1o_rdy;
      result_o <= s1o_rdy ? s2t_res : 32'd0;    // idle slots read as zero
      flags_o  <= s1o_rdy ? s2t_flags : '0;
    end
  end

endmodule

// ==== fpu_rnd_props.sv ====
// output side checks of the rounder only; values before the first reset edge are not covered
`timescale 1ns/10ps
module fpu_rnd_props import fpu_fmt_pkg::*; (
  input logic        clk,
  input logic        rst,
  input logic        valid_o,
  input logic [31:0] result_o,
  input fp_flags_t   flags_o
);

  ////////////////////////////////////////
  // output register rules
  ////////////////////////////////////////

  // cleared on the edge that sees reset
  a_no_valid_in_rst: assert property (@(posedge clk) rst |=> !valid_o)
    else $error("valid_o high while rst is high");

  // zero flag only with a signed zero
  a_zf_zero: assert property (@(posedge clk) disable iff (rst)
    flags_o.zf |-> (result_o[30:0] == 31'd0))
    else $error("zf set with nonzero magnitude %h", result_o);

  a_ovf_inf: assert property (@(posedge clk) disable iff (rst)
    flags_o.ovf |-> (result_o[30:0] == INF_BITS))  // overflow always saturates to inf
    else $error("ovf set without infinite result %h", result_o);

endmodule

bind fpu_rnd fpu_rnd_props u_rnd_props (
  .clk      (clk),
  .rst      (rst),
  .valid_o  (valid_o),
  .result_o (result_o),
  .flags_o  (flags_o)
);

// ==== fpu_top.sv ====
// fixed three-stage latency counted in adv_i edges; rmode_i must hold while ops are in flight
`timescale 1ns/10ps
module fpu_top import fpu_ops_pkg::*, fpu_fmt_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        start_i,   // one-cycle strobe, counts while adv_i is high
  input  fpu_op_e     op_i,
  input  logic [31:0] opa_i,
  input  logic [31:0] opb_i,
  input  fpu_rmode_e  rmode_i,
  input  logic        adv_i,     // pipeline advance
  input  logic        flush_i,   // drop everything in flight
  output logic [31:0] result_o,
  output logic        valid_o,
  output fp_flags_t   flags_o
);

  fp_unrnd_t add_res;
  fp_unrnd_t mul_res;

  ////////////////////////////////////////
  // arithmetic units, side by side
  ////////////////////////////////////////

  fpu_addsub u_addsub (
    .clk     (clk),
    .rst     (rst),
    .start_i (start_i),
    .op_i    (op_i),
    .opa_i   (opa_i),
    .opb_i   (opb_i),
    .rmode_i (rmode_i),  // sign of exact zero
    .adv_i   (adv_i),
    .flush_i (flush_i),
    .res_o   (add_res)
  );

  fpu_mul u_mul (
    .clk     (clk),
    .rst     (rst),
    .start_i (start_i),
    .op_i    (op_i),
    .opa_i   (opa_i),
    .opb_i   (opb_i),
    .adv_i   (adv_i),
    .flush_i (flush_i),
    .res_o   (mul_res)
  );

  // shared rounder
  fpu_rnd u_rnd (
    .clk      (clk),
    .rst      (rst),
    .adv_i    (adv_i),
    .flush_i  (flush_i),
    .rmode_i  (rmode_i),
    .add_i    (add_res),
    .mul_i    (mul_res),
    .result_o (result_o),
    .valid_o  (valid_o),
    .flags_o  (flags_o)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_fpu -f all.f &&
./obj_dir/Vtb_fpu | tee /dev/stderr | grep -qx "RESULT: PASS" &&
echo "simulation ok" || { echo "simulation failed"; exit 1; }

// ==== tb_fpu.sv ====
// fixed three-cycle latency in adv_i edges; rmode changes only with the pipeline drained
`timescale 1ns/10ps
module tb_fpu import fpu_ops_pkg::*, fpu_fmt_pkg::*;;

  localparam int NV  = 15;  // table rows
  localparam int LAT = 3;   // adv edges from drive to valid_o

  // one stimulus row with its expected response
  typedef struct packed {
    fpu_op_e     op;
    fpu_rmode_e  rmode;
    logic [31:0] opa;
    logic [31:0] opb;
    logic [31:0] res;
    fp_flags_t   flags;
  } vec_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        start_i;
  fpu_op_e     op_i;
  logic [31:0] opa_i, opb_i;
  fpu_rmode_e  rmode_i;
  logic        adv_i, flush_i;
  logic [31:0] result_o;
  logic        valid_o;
  fp_flags_t   flags_o;

  vec_t        tbl [NV];
  int          exp_idx[$];    // rows in flight, oldest first
  int          exp_at[$];     // adv count at which each one is due
  int          adv_cnt = 0;
  logic        adv_q = 1'b0;  // adv_i at the last edge
  int          errors = 0;

  fpu_top fpu_top_i (.*);

  always #2 clk = ~clk;  // 4 ns period

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_result(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_flags(input fp_flags_t got, input fp_flags_t exp);
    if (got !== exp) begin
      errors++;
      $display("Fail flags_o: got %h exp %h", got, exp);
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Fail valid_o: got %h exp %h", got, exp);
    end
  endtask

  task automatic end_sim;
    $display("checks done, errors: %0d", errors);
    if (errors == 0) $display("RESULT: PASS");
    else $display("RESULT: FAIL");
    $finish;
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // flags: ovf unf snf qnf zf ixf ivf
  task automatic load_table;
    tbl[0]  = '{FPU_ADD, RM_NEAREST, 32'h3F800000, 32'h40000000, 32'h40400000, 7'h00};
    tbl[1]  = '{FPU_SUB, RM_NEAREST, 32'h40400000, 32'h40400000, 32'h00000000, 7'h04};
    tbl[2]  = '{FPU_MUL, RM_NEAREST, 32'h3FC00000, 32'h40000000, 32'h40400000, 7'h00};
    tbl[3]  = '{FPU_ADD, RM_NEAREST, 32'h3F800000, 32'h33800000, 32'h3F800000, 7'h02};
    tbl[4]  = '{FPU_MUL, RM_NEAREST, 32'h7F000000, 32'h40800000, 32'h7F800000, 7'h42};
    tbl[5]  = '{FPU_MUL, RM_NEAREST, 32'h00800000, 32'h3F000000, 32'h00000000, 7'h26};
    tbl[6]  = '{FPU_SUB, RM_NEAREST, 32'h7F800000, 32'h7F800000, 32'h7FC00000, 7'h01};
    tbl[7]  = '{FPU_MUL, RM_NEAREST, 32'h00000000, 32'h7F800000, 32'h7FC00000, 7'h01};
    tbl[8]  = '{FPU_ADD, RM_NEAREST, 32'h7FC00000, 32'h3F800000, 32'h7FC00000, 7'h08};
    tbl[9]  = '{FPU_MUL, RM_NEAREST, 32'h7F800001, 32'h3F800000, 32'h7FC00000, 7'h11};
    tbl[10] = '{FPU_ADD, RM_TO_ZERO, 32'h3F800000, 32'h33800000, 32'h3F800000, 7'h02};
    tbl[11] = '{FPU_ADD, RM_TO_INFP, 32'h3F800000, 32'h33800000, 32'h3F800001, 7'h02};
    tbl[12] = '{FPU_ADD, RM_TO_INFM, 32'hBF800000, 32'hB3800000, 32'hBF800001, 7'h02};
    tbl[13] = '{FPU_SUB, RM_TO_INFM, 32'h40400000, 32'h40400000, 32'h80000000, 7'h04};  // -0
    tbl[14] = '{FPU_ADD, RM_NEAREST, 32'h3F800001, 32'h33800000, 32'h3F800002, 7'h02};  // tie, odd
  endtask

  // one start strobe, 1 ns after the edge
  task automatic issue(input int idx, input bit expect_out);
    @(posedge clk);
    #1;
    start_i = 1'b1;
    op_i    = tbl[idx].op;
    rmode_i = tbl[idx].rmode;
    opa_i   = tbl[idx].opa;
    opb_i   = tbl[idx].opb;
    if (expect_out) begin
      exp_idx.push_back(idx);
      exp_at.push_back(adv_cnt + LAT);
    end
  endtask

  // stop starting, wait until every expected row came out
  task automatic drain;
    int t;
    @(posedge clk);
    #1 start_i = 1'b0;
    t = 0;
    while (exp_idx.size() != 0 && t < 20) begin
      @(posedge clk);
      t++;
    end
    if (exp_idx.size() != 0) begin
      errors++;
      $display("timeout: valid_o never delivered %0d pending results", exp_idx.size());
      end_sim;
    end
  endtask

  ////////////////////////////////////////
  // output monitor
  ////////////////////////////////////////

  always @(posedge clk) begin
    adv_q <= adv_i;
    if (adv_i) adv_cnt <= adv_cnt + 1;  // only advancing edges count
  end

  // outputs settle on the edge, sampled mid cycle
  always @(negedge clk) begin : mon_blk
    int idx;
    int at;
    if (!rst && valid_o && adv_q) begin
      if (exp_idx.size() == 0) begin
        errors++;
        $display("valid_o went high with no operation in flight");
      end else begin
        idx = exp_idx.pop_front();
        at  = exp_at.pop_front();
        check_result("result_o", result_o, tbl[idx].res);
        check_flags(flags_o, tbl[idx].flags);
        if (adv_cnt != at) begin
          errors++;
          $display("row %0d came out after the wrong number of advance edges", idx);
        end
      end
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    rst     = 1'b1;
    start_i = 1'b0;
    op_i    = FPU_ADD;
    opa_i   = 32'd0;
    opb_i   = 32'd0;
    rmode_i = RM_NEAREST;
    adv_i   = 1'b1;
    flush_i = 1'b0;
    load_table();
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;

    // idle after reset, nothing started yet
    repeat (4) begin
      @(negedge clk);
      check_valid(valid_o, 1'b0);
      check_result("result_o", result_o, 32'd0);
      check_flags(flags_o, '0);
    end

    // table, back to back within one rounding mode
    for (int i = 0; i < NV; i++) begin
      if (i > 0 && tbl[i].rmode != tbl[i-1].rmode) drain();
      issue(i, 1'b1);
    end
    drain();

    // back-pressure with ops in flight
    issue(0, 1'b1);
    issue(2, 1'b1);
    issue(3, 1'b1);
    @(posedge clk);
    #1 start_i = 1'b0;
    @(posedge clk);
    #1 adv_i = 1'b0;
    // row 2 sits in the output register, row 3 behind it
    check_valid(valid_o, 1'b1);
    check_result("result_o", result_o, tbl[2].res);
    check_flags(flags_o, tbl[2].flags);
    repeat (5) begin
      @(negedge clk);
      check_valid(valid_o, 1'b1);
      check_result("result_o", result_o, tbl[2].res);
      check_flags(flags_o, tbl[2].flags);
    end
    @(posedge clk);
    #1 adv_i = 1'b1;
    drain();

    // flush with one op in every stage
    issue(0, 1'b0);
    issue(2, 1'b0);
    issue(3, 1'b0);
    flush_i = 1'b1;  // same edge samples the third start
    @(posedge clk);
    #1;
    start_i = 1'b0;
    flush_i = 1'b0;
    repeat (6) begin
      @(negedge clk);
      check_valid(valid_o, 1'b0);
    end

    end_sim();
  end

endmodule
